//--- build.f
common/cart_pkg.sv
common/cpu_bus_if.sv
bus/bus_demux.sv
logic/megaram_config.sv
logic/audio_mixer.sv
logic/cart_top.sv
tb/cart_tb.sv

//--- bus/bus_demux.sv
`timescale 1ns/1ps

module bus_demux (
    input  logic            clk108_w,
    input  logic            ram_enabled_w,
    input  cart_pkg::byte_t mp,
    input  cart_pkg::byte_t cdin,
    input  logic            rd_n,
    input  logic            wr_n,
    output cart_pkg::msel_t msel_n,
    cpu_bus_if.source       bus
);
    import cart_pkg::*;

    logic [2:0] state;       // frame position 0..6
    logic       cap_en;      // mp is valid for the current select
    logic       ctrl_cap;    // last capture of the frame
    addr_t      addr_stage;  // address bytes before publication

    ////////////////////////////// select sequencer

    // capture one cycle after each select change
    always_comb begin
        case (state)
            3'd1, 3'd3, 3'd5: cap_en = 1'b1;
            default:          cap_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            state  <= 3'd0;
            msel_n <= MSEL_NONE;
        end else begin
            if (state == 3'(FRAME_CYCLES - 1)) begin
                state <= 3'd0;
            end else begin
                state <= state + 3'd1;
            end

            case (state)
                3'd0:    msel_n <= MSEL_ADDR_LO;
                3'd2:    msel_n <= MSEL_ADDR_HI;
                3'd4:    msel_n <= MSEL_CTRL;
                3'd6:    msel_n <= MSEL_NONE;
                default: msel_n <= msel_n;  // hold during capture
            endcase
        end
    end

    assign ctrl_cap = cap_en && (msel_n == MSEL_CTRL);

    ////////////////////////////// capture

    // low and high address byte, staged until the control byte arrives
    always_ff @(posedge clk108_w) begin
        if (cap_en && msel_n == MSEL_ADDR_LO) begin
            addr_stage[BYTE_W-1:0] <= mp;
        end
        if (cap_en && msel_n == MSEL_ADDR_HI) begin
            addr_stage[ADDR_W-1:BYTE_W] <= mp;
        end
    end

    always_ff @(posedge clk108_w) begin
        if (ctrl_cap) begin
            bus.data <= cdin;  // sampled with the strobes
        end
    end

    ////////////////////////////// publish

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            bus.addr       <= '0;
            bus.merq_n     <= 1'b1;
            bus.iorq_n     <= 1'b1;
            bus.m1_n       <= 1'b1;
            bus.rfsh_n     <= 1'b1;
            bus.res_n      <= 1'b1;
            bus.rd_n       <= 1'b1;
            bus.wr_n       <= 1'b1;
            bus.frame_done <= 1'b0;
        end else begin
            bus.frame_done <= ctrl_cap;
            if (ctrl_cap) begin
                bus.addr   <= addr_stage;
                bus.merq_n <= mp[CTRL_MERQ];
                bus.iorq_n <= mp[CTRL_IORQ];
                bus.res_n  <= mp[CTRL_RES];
                bus.rfsh_n <= mp[CTRL_RFSH];
                bus.m1_n   <= mp[CTRL_M1];
                bus.rd_n   <= rd_n;
                bus.wr_n   <= wr_n;
            end
        end
    end

    // one snapshot per frame, never early and never late
    frame_period_chk: assert property (
        @(posedge clk108_w) disable iff (!ram_enabled_w)
        bus.frame_done |=> !bus.frame_done [*FRAME_CYCLES-1] ##1 bus.frame_done
    ) else $error("frame_done does not recur every %0d cycles", FRAME_CYCLES);

endmodule

//--- common/cart_pkg.sv
package cart_pkg;

    ////////////////////////////// widths
    localparam int ADDR_W   = 16;
    localparam int BYTE_W   = 8;
    localparam int SAMPLE_W = 16;
    localparam int SCC_W    = 15;  // scc waveform is 15 bit signed
    localparam int MSEL_W   = 3;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [BYTE_W-1:0]   byte_t;
    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [MSEL_W-1:0]   msel_t;

    // mapper selected through port 8fh
    typedef enum logic [1:0] {
        konami     = 2'd0,
        konami_scc = 2'd1,
        ascii16    = 2'd2,
        ascii8     = 2'd3
    } megaram_type_t;

    ////////////////////////////// bus select
    localparam msel_t MSEL_ADDR_LO = 3'b110;  // a0-a7
    localparam msel_t MSEL_ADDR_HI = 3'b101;  // a8-a15
    localparam msel_t MSEL_CTRL    = 3'b011;  // merq, iorq, res, rfsh, m1
    localparam msel_t MSEL_NONE    = 3'b111;

    localparam int FRAME_CYCLES = 7;  // select frame length

    // bit positions inside the control byte
    localparam int CTRL_MERQ = 0;
    localparam int CTRL_IORQ = 1;
    localparam int CTRL_RES  = 4;
    localparam int CTRL_RFSH = 5;
    localparam int CTRL_M1   = 7;

    ////////////////////////////// megaram config
    localparam byte_t MEGARAM_PORT = 8'h8f;
    localparam byte_t CODE_SCC     = 8'h05;
    localparam byte_t CODE_ASCII16 = 8'h16;
    localparam byte_t CODE_ASCII8  = 8'h08;

    ////////////////////////////// mixer
    localparam sample_t MIX_OFFSET = 16'h2000;  // lifts signed fm and scc terms
    localparam int      PSG_SHIFT  = 5;

endpackage

//--- common/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_bus_if;
    import cart_pkg::*;

    addr_t addr;      // full 16 bit cpu address
    logic  merq_n;
    logic  iorq_n;
    logic  m1_n;
    logic  rfsh_n;
    logic  res_n;
    logic  rd_n;
    logic  wr_n;
    byte_t data;      // cd bus byte of this frame
    logic  frame_done;  // one cycle, new snapshot

    // demux side
    modport source (
        output addr, merq_n, iorq_n, m1_n, rfsh_n, res_n, rd_n, wr_n, data,
        output frame_done
    );

    // consumers, no back-pressure
    modport sink (
        input addr, merq_n, iorq_n, m1_n, rfsh_n, res_n, rd_n, wr_n, data,
        input frame_done
    );

endinterface

//--- logic/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
    input  logic                         clk108_w,
    input  logic                         ram_enabled_w,
    input  cart_pkg::sample_t            opll_wave,
    input  logic [cart_pkg::SCC_W-1:0]   scc_wave,
    input  cart_pkg::byte_t              psg_wave,
    output cart_pkg::sample_t            sound_sample
);
    import cart_pkg::*;

    sample_t fm_half;     // opll >>> 1
    sample_t scc_half;    // scc sign extended, >>> 1
    sample_t psg_scaled;

    // stage 1
    sample_t fm_term;
    sample_t scc_term;
    sample_t psg_term;

    // stage 2
    sample_t mix_sum;

    assign fm_half    = {opll_wave[SAMPLE_W-1], opll_wave[SAMPLE_W-1:1]};
    assign scc_half   = {{(SAMPLE_W - SCC_W + 1){scc_wave[SCC_W-1]}}, scc_wave[SCC_W-1:1]};
    assign psg_scaled = sample_t'(psg_wave) << PSG_SHIFT;  // unsigned, zero filled

    ////////////////////////////// pipeline

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            fm_term  <= '0;
            scc_term <= '0;
            psg_term <= '0;
        end else begin
            fm_term  <= fm_half + MIX_OFFSET;
            scc_term <= scc_half + MIX_OFFSET;
            psg_term <= psg_scaled;
        end
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mix_sum <= '0;
        end else begin
            mix_sum <= fm_term + scc_term + psg_term;  // wraps mod 2^16
        end
    end

    // double the sample unless the top bit is already set
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sound_sample <= '0;
        end else if (mix_sum[SAMPLE_W-1]) begin
            sound_sample <= mix_sum;
        end else begin
            sound_sample <= {mix_sum[SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

//--- logic/cart_top.sv
`timescale 1ns/1ps

module cart_top (
    input  logic                       clk108_w,
    input  logic                       ram_enabled_w,
    input  cart_pkg::byte_t            mp,
    input  cart_pkg::byte_t            cdin,
    input  logic                       rd_n,
    input  logic                       wr_n,
    input  cart_pkg::sample_t          opll_wave,
    input  logic [cart_pkg::SCC_W-1:0] scc_wave,
    input  cart_pkg::byte_t            psg_wave,
    output cart_pkg::msel_t            msel_n,
    output cart_pkg::addr_t            addr,
    output logic                       merq_n,
    output logic                       iorq_n,
    output logic                       m1_n,
    output logic                       rfsh_n,
    output logic                       res_n,
    output logic                       frame_done,
    output logic [1:0]                 mapper_type,
    output logic                       scc_enable,
    output cart_pkg::sample_t          sound_sample
);

    cpu_bus_if bus_if ();

    ////////////////////////////// bus front end
    bus_demux bus_demux_inst (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .cdin          (cdin),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .msel_n        (msel_n),
        .bus           (bus_if.source)
    );

    megaram_config megaram_config_inst (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .bus           (bus_if.sink),
        .mapper_type   (mapper_type),
        .scc_enable    (scc_enable)
    );

    // snapshot fields out to pins
    assign addr       = bus_if.addr;
    assign merq_n     = bus_if.merq_n;
    assign iorq_n     = bus_if.iorq_n;
    assign m1_n       = bus_if.m1_n;
    assign rfsh_n     = bus_if.rfsh_n;
    assign res_n      = bus_if.res_n;
    assign frame_done = bus_if.frame_done;

    ////////////////////////////// audio
    audio_mixer audio_mixer_inst (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .opll_wave     (opll_wave),
        .scc_wave      (scc_wave),
        .psg_wave      (psg_wave),
        .sound_sample  (sound_sample)
    );

endmodule

//--- logic/megaram_config.sv
`timescale 1ns/1ps

module megaram_config (
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    cpu_bus_if.sink                 bus,
    output cart_pkg::megaram_type_t mapper_type,
    output logic                    scc_enable
);
    import cart_pkg::*;

    logic cfg_wr;

    // plain i/o write to port 8fh, m1 cycles excluded
    assign cfg_wr = bus.frame_done && !bus.iorq_n && bus.m1_n && !bus.wr_n && bus.rd_n &&
                    (bus.addr[BYTE_W-1:0] == MEGARAM_PORT);

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mapper_type <= konami_scc;  // power up as konami scc
            scc_enable  <= 1'b1;
        end else if (cfg_wr) begin
            case (bus.data)
                CODE_SCC: begin
                    mapper_type <= konami_scc;
                    scc_enable  <= 1'b1;
                end
                CODE_ASCII16: begin
                    mapper_type <= ascii16;
                    scc_enable  <= 1'b0;
                end
                CODE_ASCII8: begin
                    mapper_type <= ascii8;
                    scc_enable  <= 1'b0;
                end
                default: begin
                    mapper_type <= konami;  // any other code
                    scc_enable  <= 1'b0;
                end
            endcase
        end
    end

    // scc only exists on the konami scc mapper
    scc_type_chk: assert property (
        @(posedge clk108_w) disable iff (!ram_enabled_w)
        scc_enable == (mapper_type == konami_scc)
    ) else $error("scc_enable out of step with mapper_type");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f build.f --top-module cart_tb -Mdir "$OBJ" -o cart_sim
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator compile failed"
    exit 1
fi

"./$OBJ/cart_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    echo "run_sim: result pass"
    exit 0
fi

echo "run_sim: result fail, see $LOG"
exit 1

//--- tb/bus_cases.txt
# name addr ctrl rd_n wr_n cdin opll scc psg mapper, all hex
# ctrl bits: 0 merq_n, 1 iorq_n, 4 res_n, 5 rfsh_n, 7 m1_n; mapper 0 konami, 1 scc, 2 a16, 3 a8
mem_read     4000 FE 0 1 00 0000 0000 00 1
cfg_ascii16  008F FD 1 0 16 1234 0100 10 2
cfg_m1_write 008F 7D 1 0 08 0F00 0200 20 2
cfg_read_8f  008F FD 0 1 08 00F0 0300 30 2
cfg_port_8e  008E FD 1 0 08 0001 0400 40 2
cfg_ascii8   008F FD 1 0 08 2000 0500 50 3
cfg_konami   A58F FD 1 0 42 3000 0600 60 0
cfg_scc      008F FD 1 0 05 0400 0700 70 1
fm_negative  8123 FE 0 1 00 8000 0100 00 1
scc_negative C0DE FE 1 0 5A 0100 4000 08 1
sum_top_set  FFFF FE 0 1 00 7FFE 3FFF FF 1
refresh      3F00 DE 1 1 00 0000 7FFF 01 1
reset_low    0000 EF 1 1 00 FFFF 0000 80 1
mem_write    E000 FE 1 0 C3 A5A5 5A5A C3 1
cfg_other    008F FD 1 0 FF 4000 2000 FF 0
cfg_ascii16b 148F FD 1 0 16 C000 6000 11 2
io_read      0098 FD 0 1 00 0000 0000 00 2

//--- tb/cart_tb.sv
`timescale 1ns/1ps

module cart_tb;
    import cart_pkg::*;

    localparam int MAX_CASES = 32;

    logic                 clk108_w = 1'b0;
    logic                 ram_enabled_w;
    byte_t                mp = 8'hff;
    byte_t                cdin;
    logic                 rd_n;
    logic                 wr_n;
    sample_t              opll_wave;
    logic [SCC_W-1:0]     scc_wave;
    byte_t                psg_wave;
    msel_t                msel_n;
    addr_t                addr;
    logic                 merq_n, iorq_n, m1_n, rfsh_n, res_n;
    logic                 frame_done;
    logic [1:0]           mapper_type;
    logic                 scc_enable;
    sample_t              sound_sample;

    // case table filled from tb/bus_cases.txt
    string                case_name [MAX_CASES];
    addr_t                case_addr [MAX_CASES];
    byte_t                case_ctrl [MAX_CASES];
    logic                 case_rd   [MAX_CASES];
    logic                 case_wr   [MAX_CASES];
    byte_t                case_cd   [MAX_CASES];
    sample_t              case_opll [MAX_CASES];
    logic [SCC_W-1:0]     case_scc  [MAX_CASES];
    byte_t                case_psg  [MAX_CASES];
    logic [1:0]           case_map  [MAX_CASES];

    addr_t                cur_addr;   // what the bus model multiplexes onto mp
    byte_t                cur_ctrl;
    int                   errors = 0;
    int                   case_errs = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    int                   cycle_count = 0;
    int                   cycle_limit = 0;

    // msel_n as seen on the falling edges of one frame after reset
    msel_t msel_seq [FRAME_CYCLES] = '{MSEL_ADDR_LO, MSEL_ADDR_LO, MSEL_ADDR_HI, MSEL_ADDR_HI,
                                       MSEL_CTRL, MSEL_CTRL, MSEL_NONE};

    cart_top cart_top_inst (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .cdin          (cdin),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .opll_wave     (opll_wave),
        .scc_wave      (scc_wave),
        .psg_wave      (psg_wave),
        .msel_n        (msel_n),
        .addr          (addr),
        .merq_n        (merq_n),
        .iorq_n        (iorq_n),
        .m1_n          (m1_n),
        .rfsh_n        (rfsh_n),
        .res_n         (res_n),
        .frame_done    (frame_done),
        .mapper_type   (mapper_type),
        .scc_enable    (scc_enable),
        .sound_sample  (sound_sample)
    );

    always #50 clk108_w = ~clk108_w;  // 100 ns period

    ////////////////////////////// bus model

    always @(negedge clk108_w) begin
        case (msel_n)
            MSEL_ADDR_LO: mp <= cur_addr[7:0];
            MSEL_ADDR_HI: mp <= cur_addr[15:8];
            MSEL_CTRL:    mp <= cur_ctrl;
            default:      mp <= 8'hff;  // bus idle
        endcase
    end

    always @(posedge clk108_w) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_limit > 0);
        wait (cycle_count >= cycle_limit);
        $display("timeout after %0d cycles, the DUT stopped producing frames", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////// helpers

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("error %s: %s expected %0h actual %0h", test, what, expected, actual);
            case_errs++;
        end
    endtask

    task automatic close_test(input string test);
        tests_run++;
        if (case_errs == 0) begin
            $display("test %s ok", test);
        end else begin
            $display("test %s failed with %0d mismatches", test, case_errs);
            tests_failed++;
            errors += case_errs;
        end
        case_errs = 0;
    endtask

    // counts falling edges up to and including the next frame_done
    task automatic wait_frame(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk108_w);
            cycles++;
        end while (!frame_done);
    endtask

    // scale, offset, sum, then double unless bit 15 is set
    function automatic sample_t expected_mix(sample_t opll, logic [SCC_W-1:0] scc, byte_t psg);
        int      fm;
        int      sc;
        int      sum;
        sample_t s16;
        fm  = int'($signed(opll));
        sc  = int'($signed(scc));
        fm  = (fm >>> 1) + int'(MIX_OFFSET);
        sc  = (sc >>> 1) + int'(MIX_OFFSET);
        sum = fm + sc + (int'(psg) << PSG_SHIFT);
        s16 = sum[15:0];
        if (s16[15]) begin
            return s16;
        end
        return s16 << 1;
    endfunction

    task automatic load_cases(output int count);
        int          fd;
        int          got;
        string       line;
        string       name;
        logic [31:0] a, c, r, w, d, o, s, p, e;
        count = 0;
        fd = $fopen("tb/bus_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file tb/bus_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && count < MAX_CASES) begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                                  name, a, c, r, w, d, o, s, p, e);
                    if (got == 10) begin
                        case_name[count] = name;
                        case_addr[count] = a[15:0];
                        case_ctrl[count] = c[7:0];
                        case_rd[count]   = r[0];
                        case_wr[count]   = w[0];
                        case_cd[count]   = d[7:0];
                        case_opll[count] = o[15:0];
                        case_scc[count]  = s[SCC_W-1:0];
                        case_psg[count]  = p[7:0];
                        case_map[count]  = e[1:0];
                        count++;
                    end else begin
                        $display("malformed line in the case file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (count == 0) begin
                $display("the case file holds no cases");
                errors++;
            end
        end
    endtask

    ////////////////////////////// main sequence

    initial begin
        int      n_cases;
        int      gap;
        sample_t prev_mix;  // mixer result of the inputs before the change
        ram_enabled_w = 1'b0;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        cdin          = 8'h00;
        opll_wave     = '0;
        scc_wave      = '0;
        psg_wave      = 8'h00;
        cur_addr      = '0;
        cur_ctrl      = 8'hff;  // all strobes inactive

        load_cases(n_cases);
        cycle_limit = (n_cases * 2 + 4) * FRAME_CYCLES + 16 + 50;
        repeat (16) @(negedge clk108_w);

        if (n_cases > 0) begin
            // still in reset here
            check_value("reset_state", "msel_n", 32'(MSEL_NONE), 32'(msel_n));
            check_value("reset_state", "frame_done", 32'd0, 32'(frame_done));
            check_value("reset_state", "addr", 32'd0, 32'(addr));
            check_value("reset_state", "strobes", 32'h1f,
                        32'({merq_n, iorq_n, m1_n, rfsh_n, res_n}));
            check_value("reset_state", "mapper_type", 32'(konami_scc), 32'(mapper_type));
            check_value("reset_state", "scc_enable", 32'd1, 32'(scc_enable));
            check_value("reset_state", "sound_sample", 32'd0, 32'(sound_sample));
            close_test("reset_state");
            ram_enabled_w <= 1'b1;

            for (int k = 0; k < FRAME_CYCLES; k++) begin
                @(negedge clk108_w);
                check_value("frame_seq", "msel_n", 32'(msel_seq[k]), 32'(msel_n));
                check_value("frame_seq", "frame_done",
                            (k == FRAME_CYCLES - 2) ? 32'd1 : 32'd0, 32'(frame_done));
                if (k < FRAME_CYCLES - 2) begin
                    check_value("frame_seq", "strobes before first frame", 32'h1f,
                                32'({merq_n, iorq_n, m1_n, rfsh_n, res_n}));
                end
            end
            close_test("frame_seq");
            wait_frame(gap);  // line up on a frame_done edge
            prev_mix = expected_mix(opll_wave, scc_wave, psg_wave);

            for (int i = 0; i < n_cases; i++) begin
                cur_addr  <= case_addr[i];
                cur_ctrl  <= case_ctrl[i];
                rd_n      <= case_rd[i];
                wr_n      <= case_wr[i];
                cdin      <= case_cd[i];
                opll_wave <= case_opll[i];
                scc_wave  <= case_scc[i];
                psg_wave  <= case_psg[i];

                // old sample still on the output until the third edge
                repeat (2) @(negedge clk108_w);
                check_value(case_name[i], "sound_sample held", 32'(prev_mix),
                            32'(sound_sample));
                @(negedge clk108_w);  // mixer latency reached
                prev_mix = expected_mix(case_opll[i], case_scc[i], case_psg[i]);
                check_value(case_name[i], "sound_sample", 32'(prev_mix), 32'(sound_sample));

                wait_frame(gap);
                check_value(case_name[i], "frame period", FRAME_CYCLES, gap + 3);
                check_value(case_name[i], "addr", 32'(case_addr[i]), 32'(addr));
                check_value(case_name[i], "merq_n", 32'(case_ctrl[i][CTRL_MERQ]), 32'(merq_n));
                check_value(case_name[i], "iorq_n", 32'(case_ctrl[i][CTRL_IORQ]), 32'(iorq_n));
                check_value(case_name[i], "m1_n", 32'(case_ctrl[i][CTRL_M1]), 32'(m1_n));
                check_value(case_name[i], "rfsh_n", 32'(case_ctrl[i][CTRL_RFSH]), 32'(rfsh_n));
                check_value(case_name[i], "res_n", 32'(case_ctrl[i][CTRL_RES]), 32'(res_n));

                // config register has had a full frame to settle
                wait_frame(gap);
                check_value(case_name[i], "frame period", FRAME_CYCLES, gap);
                check_value(case_name[i], "mapper_type", 32'(case_map[i]), 32'(mapper_type));
                check_value(case_name[i], "scc_enable",
                            (case_map[i] == konami_scc) ? 32'd1 : 32'd0, 32'(scc_enable));
                close_test(case_name[i]);
            end
        end

        $display("summary: %0d tests, %0d ok, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
